// File: ex_stage.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/ex_control.sv
hdl/ex_operands.sv
hdl/ex_alu.sv
hdl/csr_unit.sv
hdl/ex_mem_reg.sv
hdl/ex_stage.sv
tests/tb_ex_stage.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_ex_stage -f ex_stage.f
	./obj_dir/Vtb_ex_stage 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: tests/tb_ex_stage.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module tb_ex_stage import rv_pkg::*; ();

    localparam int N_ALU   = 80;
    localparam int N_ADDR  = 10;
    localparam int N_FWD   = 80;
    localparam int N_BR    = 80;
    // Address rounds issue six instructions each, the CSR block five
    localparam int N_TESTS = 2 * N_ALU + 6 * N_ADDR + N_FWD + N_BR + 5;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        ex_valid;
    rv_inst_u    inst;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    rv_inst_u    mem_inst;
    logic [31:0] mem_fwd_data;
    rv_inst_u    wb_inst;
    logic [31:0] wb_fwd_data;
    logic        br_taken;
    ex_mem_t     ex_mem;
    logic [31:0] csr_tohost;
    logic        br_mispred;
    logic        br_suc;
    logic        flush;

    integer      seed = 65;
    int          errors = 0;
    logic        rst_chk;
    logic        pend_en;
    logic        chk_en;
    logic [31:0] pend_alu;
    logic [31:0] pend_st;
    logic [31:0] chk_alu;
    logic [31:0] chk_st;
    logic        chk_valid;
    logic [31:0] chk_inst;
    logic [31:0] model_tohost;
    logic [31:0] chk_tohost;
    logic        exp_suc;
    logic        exp_mis;

    ex_stage i_ex_stage (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    // Older instruction in MEM or WB with a small rd range so that matches are common
    function automatic logic [31:0] older_inst(logic [1:0] sel, logic [1:0] rd);
        logic [6:0] op;
        case (sel)
            2'd0:    op = `OPC_ARI_RTYPE;
            2'd1:    op = `OPC_LOAD;
            2'd2:    op = `OPC_STORE;
            default: op = `OPC_BRANCH;
        endcase
        return {20'd0, 3'd0, rd, op};
    endfunction

    function automatic logic writes_rd(logic [31:0] w);
        return w[11:7] != 5'd0 && w[6:0] != `OPC_STORE && w[6:0] != `OPC_BRANCH;
    endfunction

    function automatic logic [31:0] fwd_ref(logic [4:0] idx, logic used, logic [31:0] reg_val);
        if (!used || idx == 5'd0) return reg_val;
        if (writes_rd(mem_inst.raw) && mem_inst.raw[11:7] == idx) return mem_fwd_data;
        if (writes_rd(wb_inst.raw) && wb_inst.raw[11:7] == idx) return wb_fwd_data;
        return reg_val;
    endfunction

    function automatic logic [31:0] arith_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                              logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] got);
        errors++;
        $display("FAIL %s expected=%h actual=%h", name, exp, got);
    endtask

    // Moves last cycle's expectations to the checkers and idles the inputs
    task automatic next_cycle();
        @(posedge clk);
        #1;
        chk_alu      = pend_alu;
        chk_st       = pend_st;
        chk_en       = pend_en;
        chk_valid    = ex_valid;
        chk_inst     = inst.raw;
        chk_tohost   = model_tohost;
        pend_en      = 1'b0;
        exp_suc      = 1'b0;
        exp_mis      = 1'b0;
        ex_valid     = 1'b0;
        inst         = `NOP_INST;
        mem_inst     = `NOP_INST;
        wb_inst      = `NOP_INST;
        br_taken     = 1'b0;
        pc           = $random(seed) & 32'hffff_fffc;
        rs1_data     = $random(seed);
        rs2_data     = $random(seed);
        mem_fwd_data = $random(seed);
        wb_fwd_data  = $random(seed);
    endtask

    task automatic expect_data(logic [31:0] alu);
        logic uses_rs2;
        uses_rs2 = inst.raw[6:0] inside {`OPC_ARI_RTYPE, `OPC_STORE, `OPC_BRANCH};
        pend_alu = alu;
        pend_st  = fwd_ref(inst.raw[24:20], uses_rs2, rs2_data);
        pend_en  = 1'b1;
    endtask

    task automatic run_alu(logic rtype);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [31:0] b;
        next_cycle();
        f3       = 3'($random(seed));
        alt      = 1'($random(seed));
        imm      = 12'($random(seed));
        ex_valid = 1'b1;
        if (rtype) begin
            inst = enc_r({1'b0, alt, 5'd0}, 5'($random(seed)), 5'($random(seed)), f3,
                         5'($random(seed)), `OPC_ARI_RTYPE);
            b = rs2_data;
        end else begin
            // Shift immediates carry shamt plus the arithmetic bit
            if (f3 == `FNC_SLL || f3 == `FNC_SRL_SRA) begin
                imm = {1'b0, alt, 5'd0, imm[4:0]};
            end else begin
                alt = 1'b0;
            end
            inst = enc_i(imm, 5'($random(seed)), f3, 5'($random(seed)), `OPC_ARI_ITYPE);
            b = {{20{imm[11]}}, imm};
        end
        expect_data(arith_ref(f3, alt, rs1_data, b));
    endtask

    task automatic run_addr();
        logic [11:0] imm;
        logic [19:0] uimm;
        logic [20:0] jimm;
        imm  = 12'($random(seed));
        uimm = 20'($random(seed));
        jimm = {20'($random(seed)), 1'b0};
        next_cycle();
        ex_valid = 1'b1;
        inst = enc_i(imm, 5'($random(seed)), 3'b010, 5'($random(seed)), `OPC_LOAD);
        expect_data(rs1_data + {{20{imm[11]}}, imm});
        next_cycle();
        ex_valid = 1'b1;
        inst = enc_s(imm, 5'($random(seed)), 5'($random(seed)), 3'b010);
        expect_data(rs1_data + {{20{imm[11]}}, imm});
        next_cycle();
        ex_valid = 1'b1;
        inst = enc_u(uimm, 5'($random(seed)), `OPC_LUI);
        expect_data({uimm, 12'd0});
        next_cycle();
        ex_valid = 1'b1;
        inst = enc_u(uimm, 5'($random(seed)), `OPC_AUIPC);
        expect_data(pc + {uimm, 12'd0});
        next_cycle();
        ex_valid = 1'b1;
        inst = enc_j(jimm, 5'($random(seed)));
        expect_data(pc + {{11{jimm[20]}}, jimm});
        next_cycle();
        ex_valid = 1'b1;
        inst = enc_i(imm, 5'($random(seed)), 3'b000, 5'($random(seed)), `OPC_JALR);
        expect_data(pc + {{20{imm[11]}}, imm});
    endtask

    task automatic run_fwd();
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        next_cycle();
        ex_valid = 1'b1;
        mem_inst = older_inst(2'($random(seed)), 2'($random(seed)));
        wb_inst  = older_inst(2'($random(seed)), 2'($random(seed)));
        rs1      = {3'd0, 2'($random(seed))};
        rs2      = {3'd0, 2'($random(seed))};
        imm      = 12'($random(seed));
        if (1'($random(seed))) begin
            inst = enc_r(7'd0, rs2, rs1, `FNC_ADD_SUB, 5'd9, `OPC_ARI_RTYPE);
            expect_data(fwd_ref(rs1, 1'b1, rs1_data) + fwd_ref(rs2, 1'b1, rs2_data));
        end else begin
            inst = enc_s(imm, rs2, rs1, 3'b010);
            expect_data(fwd_ref(rs1, 1'b1, rs1_data) + {{20{imm[11]}}, imm});
        end
    endtask

    task automatic run_branch();
        logic [2:0]  f3;
        logic [12:0] bimm;
        logic        taken;
        next_cycle();
        ex_valid = 1'b1;
        f3       = 3'($random(seed));
        // Codes 2 and 3 are not branches
        if (f3 == 3'd2 || f3 == 3'd3) begin
            f3 = f3 + 3'd2;
        end
        bimm     = {12'($random(seed)), 1'b0};
        br_taken = 1'($random(seed));
        if (1'($random(seed))) begin
            rs2_data = rs1_data;
        end
        inst = enc_b(bimm, 5'($random(seed)), 5'($random(seed)), f3);
        case (f3)
            `FNC_BEQ:  taken = rs1_data == rs2_data;
            `FNC_BNE:  taken = rs1_data != rs2_data;
            `FNC_BLT:  taken = $signed(rs1_data) < $signed(rs2_data);
            `FNC_BGE:  taken = $signed(rs1_data) >= $signed(rs2_data);
            `FNC_BLTU: taken = rs1_data < rs2_data;
            default:   taken = rs1_data >= rs2_data;
        endcase
        exp_suc = taken == br_taken;
        exp_mis = taken != br_taken;
        expect_data(pc + {{19{bimm[12]}}, bimm});
    endtask

    task automatic run_csr();
        logic [4:0] uimm;
        uimm = 5'($random(seed));
        // CSRRW with rs1 coming from MEM
        next_cycle();
        ex_valid = 1'b1;
        mem_inst = enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd6, `OPC_ARI_RTYPE);
        inst = enc_i(`CSR_TOHOST, 5'd6, `FNC_CSRRW, 5'd0, `OPC_CSR);
        model_tohost = fwd_ref(5'd6, 1'b1, rs1_data);
        next_cycle();
        ex_valid = 1'b1;
        inst = enc_i(`CSR_TOHOST, uimm, `FNC_CSRRWI, 5'd0, `OPC_CSR);
        model_tohost = {27'd0, uimm};
        next_cycle();
        ex_valid = 1'b1;
        inst = enc_i(12'h340, 5'd7, `FNC_CSRRW, 5'd0, `OPC_CSR);
        next_cycle();
        inst = enc_i(`CSR_TOHOST, 5'd7, `FNC_CSRRW, 5'd0, `OPC_CSR);
        next_cycle();
        ex_valid = 1'b1;
        inst = enc_i(`CSR_TOHOST, 5'd7, `FNC_CSRRW, 5'd0, `OPC_CSR);
        model_tohost = rs1_data;
    endtask

    assert property (@(posedge clk) rst_chk |-> !ex_mem.valid)
        else report_mismatch("ex_mem.valid", 32'd0, 32'($sampled(ex_mem.valid)));
    assert property (@(posedge clk) rst_chk |-> ex_mem.inst.raw == `NOP_INST)
        else report_mismatch("ex_mem.inst", `NOP_INST, $sampled(ex_mem.inst.raw));
    assert property (@(posedge clk) rst_chk |-> csr_tohost == 32'd0)
        else report_mismatch("csr_tohost", 32'd0, $sampled(csr_tohost));
    assert property (@(posedge clk) disable iff (!arst_n) ex_mem.valid == chk_valid)
        else report_mismatch("ex_mem.valid", 32'($sampled(chk_valid)),
                             32'($sampled(ex_mem.valid)));
    assert property (@(posedge clk) disable iff (!arst_n) ex_mem.inst.raw == chk_inst)
        else report_mismatch("ex_mem.inst", $sampled(chk_inst), $sampled(ex_mem.inst.raw));
    assert property (@(posedge clk) disable iff (!arst_n) chk_en |-> ex_mem.alu_result == chk_alu)
        else report_mismatch("ex_mem.alu_result", $sampled(chk_alu),
                             $sampled(ex_mem.alu_result));
    assert property (@(posedge clk) disable iff (!arst_n) chk_en |-> ex_mem.store_data == chk_st)
        else report_mismatch("ex_mem.store_data", $sampled(chk_st),
                             $sampled(ex_mem.store_data));
    assert property (@(posedge clk) disable iff (!arst_n) csr_tohost == chk_tohost)
        else report_mismatch("csr_tohost", $sampled(chk_tohost), $sampled(csr_tohost));
    assert property (@(posedge clk) disable iff (!arst_n) br_suc == exp_suc)
        else report_mismatch("br_suc", 32'($sampled(exp_suc)), 32'($sampled(br_suc)));
    assert property (@(posedge clk) disable iff (!arst_n) br_mispred == exp_mis)
        else report_mismatch("br_mispred", 32'($sampled(exp_mis)), 32'($sampled(br_mispred)));
    assert property (@(posedge clk) disable iff (!arst_n) flush == exp_mis)
        else report_mismatch("flush", 32'($sampled(exp_mis)), 32'($sampled(flush)));

    initial begin
        #((N_TESTS + 40) * 8);
        $display("Watchdog expired before all instructions were issued");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        arst_n       = 1'b0;
        rst_chk      = 1'b0;
        ex_valid     = 1'b0;
        inst         = `NOP_INST;
        mem_inst     = `NOP_INST;
        wb_inst      = `NOP_INST;
        pc           = 32'd0;
        rs1_data     = 32'd0;
        rs2_data     = 32'd0;
        mem_fwd_data = 32'd0;
        wb_fwd_data  = 32'd0;
        br_taken     = 1'b0;
        pend_en      = 1'b0;
        chk_en       = 1'b0;
        pend_alu     = 32'd0;
        pend_st      = 32'd0;
        chk_alu      = 32'd0;
        chk_st       = 32'd0;
        chk_valid    = 1'b0;
        chk_inst     = `NOP_INST;
        model_tohost = 32'd0;
        chk_tohost   = 32'd0;
        exp_suc      = 1'b0;
        exp_mis      = 1'b0;
        @(posedge clk);
        #1;
        rst_chk = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // Reset state is still checked at the first edge after release
        next_cycle();
        rst_chk = 1'b0;
        repeat (N_ALU) run_alu(1'b1);
        repeat (N_ALU) run_alu(1'b0);
        repeat (N_ADDR) run_addr();
        repeat (N_FWD) run_fwd();
        repeat (N_BR) run_branch();
        run_csr();
        repeat (2) next_cycle();
        $display("Instructions issued: %0d, errors: %0d", N_TESTS, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/ex_stage.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module ex_stage import rv_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             ex_valid,
    input  rv_inst_u         inst,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  rv_inst_u         mem_inst,
    input  logic [`XLEN-1:0] mem_fwd_data,
    input  rv_inst_u         wb_inst,
    input  logic [`XLEN-1:0] wb_fwd_data,
    input  logic             br_taken,
    output ex_mem_t          ex_mem,
    output logic [`XLEN-1:0] csr_tohost,
    output logic             br_mispred,
    output logic             br_suc,
    output logic             flush
);

    ex_ctrl_t         ctrl;
    logic             breq;
    logic             brlt;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] rs1_fwd;
    logic [`XLEN-1:0] rs2_fwd;
    logic [`XLEN-1:0] alu_result;

    ex_control i_ex_control (
        .inst       (inst),
        .mem_inst   (mem_inst),
        .wb_inst    (wb_inst),
        .breq       (breq),
        .brlt       (brlt),
        .br_taken   (br_taken),
        .ctrl       (ctrl),
        .br_mispred (br_mispred),
        .br_suc     (br_suc),
        .flush      (flush)
    );

    ex_operands i_ex_operands (
        .inst         (inst),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .mem_fwd_data (mem_fwd_data),
        .wb_fwd_data  (wb_fwd_data),
        .ctrl         (ctrl),
        .op_a         (op_a),
        .op_b         (op_b),
        .rs1_fwd      (rs1_fwd),
        .rs2_fwd      (rs2_fwd),
        .breq         (breq),
        .brlt         (brlt)
    );

    ex_alu i_ex_alu (
        .ex_valid   (ex_valid),
        .op_a       (op_a),
        .op_b       (op_b),
        .ctrl       (ctrl),
        .alu_result (alu_result)
    );

    csr_unit i_csr_unit (
        .clk        (clk),
        .arst_n     (arst_n),
        .ex_valid   (ex_valid),
        .inst       (inst),
        .rs1_fwd    (rs1_fwd),
        .ctrl       (ctrl),
        .csr_tohost (csr_tohost)
    );

    ex_mem_reg i_ex_mem_reg (
        .clk        (clk),
        .arst_n     (arst_n),
        .ex_valid   (ex_valid),
        .inst       (inst),
        .alu_result (alu_result),
        .rs2_fwd    (rs2_fwd),
        .ex_mem     (ex_mem)
    );

endmodule

// File: hdl/ex_mem_reg.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module ex_mem_reg import rv_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             ex_valid,
    input  rv_inst_u         inst,
    input  logic [`XLEN-1:0] alu_result,
    input  logic [`XLEN-1:0] rs2_fwd,
    output ex_mem_t          ex_mem
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem.valid      <= 1'b0;
            ex_mem.inst.raw   <= `NOP_INST;
            ex_mem.alu_result <= '0;
            ex_mem.store_data <= '0;
        end else begin
            ex_mem.valid      <= ex_valid;
            ex_mem.inst       <= inst;
            ex_mem.alu_result <= alu_result;
            // Forwarded value so a store sees the newest rs2
            ex_mem.store_data <= rs2_fwd;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(ex_mem.valid))
        else $error("ex_mem.valid unknown");

endmodule

// File: hdl/csr_unit.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module csr_unit import rv_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             ex_valid,
    input  rv_inst_u         inst,
    input  logic [`XLEN-1:0] rs1_fwd,
    input  ex_ctrl_t         ctrl,
    output logic [`XLEN-1:0] csr_tohost
);

    logic             wr_en;
    logic [`XLEN-1:0] wr_data;

    assign wr_en   = ex_valid && ctrl.csr_en && inst.i.imm == `CSR_TOHOST;
    // CSRRWI takes the zero-extended rs1 field
    assign wr_data = (ctrl.csr_mux_sel == `CSR_IMM) ? {{(`XLEN-5){1'b0}}, inst.i.rs1} : rs1_fwd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_tohost <= '0;
        end else if (wr_en) begin
            csr_tohost <= wr_data;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) $changed(csr_tohost) |-> $past(wr_en))
        else $error("tohost changed without a write");

endmodule

// File: hdl/ex_alu.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module ex_alu import rv_pkg::*; (
    input  logic             ex_valid,
    input  logic [`XLEN-1:0] op_a,
    input  logic [`XLEN-1:0] op_b,
    input  ex_ctrl_t         ctrl,
    output logic [`XLEN-1:0] alu_result
);

    logic [4:0] shamt;

    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alusel)
            `ALU_ADD:  alu_result = op_a + op_b;
            `ALU_SUB:  alu_result = op_a - op_b;
            `ALU_AND:  alu_result = op_a & op_b;
            `ALU_OR:   alu_result = op_a | op_b;
            `ALU_XOR:  alu_result = op_a ^ op_b;
            `ALU_SLL:  alu_result = op_a << shamt;
            `ALU_SRL:  alu_result = op_a >> shamt;
            `ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
            `ALU_SLT:  alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            `ALU_SLTU: alu_result = {{(`XLEN-1){1'b0}}, op_a < op_b};
            `ALU_BSEL: alu_result = op_b;
            default:   alu_result = '0;
        endcase
    end

    // Decoder must never hand over an unused code
    always_comb begin
        assert final (!ex_valid || ctrl.alusel <= `ALU_BSEL)
            else $error("undefined alusel %h", ctrl.alusel);
    end

endmodule

// File: hdl/ex_operands.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module ex_operands import rv_pkg::*; (
    input  rv_inst_u         inst,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic [`XLEN-1:0] mem_fwd_data,
    input  logic [`XLEN-1:0] wb_fwd_data,
    input  ex_ctrl_t         ctrl,
    output logic [`XLEN-1:0] op_a,
    output logic [`XLEN-1:0] op_b,
    output logic [`XLEN-1:0] rs1_fwd,
    output logic [`XLEN-1:0] rs2_fwd,
    output logic             breq,
    output logic             brlt
);

    logic [`XLEN-1:0] imm;

    function automatic logic [`XLEN-1:0] fwd_mux(
        input logic [1:0]       sel,
        input logic [`XLEN-1:0] reg_val,
        input logic [`XLEN-1:0] mem_val,
        input logic [`XLEN-1:0] wb_val
    );
        case (sel)
            `EX_FWD_MEM: return mem_val;
            `EX_FWD_WB:  return wb_val;
            default:     return reg_val;
        endcase
    endfunction

    always_comb begin
        case (inst.i.opcode)
            `OPC_LOAD, `OPC_ARI_ITYPE, `OPC_JALR, `OPC_CSR:
                imm = {{20{inst.i.imm[11]}}, inst.i.imm};
            `OPC_STORE:
                imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            `OPC_BRANCH:
                imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                       inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            `OPC_LUI, `OPC_AUIPC:
                imm = {inst.u.imm, 12'd0};
            `OPC_JAL:
                imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                       inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            default:
                imm = '0;
        endcase
    end

    assign rs1_fwd = fwd_mux(ctrl.fwda, rs1_data, mem_fwd_data, wb_fwd_data);
    assign rs2_fwd = fwd_mux(ctrl.fwdb, rs2_data, mem_fwd_data, wb_fwd_data);

    assign op_a = (ctrl.asel == `A_PC) ? pc : rs1_fwd;
    assign op_b = (ctrl.bsel == `B_IMM) ? imm : rs2_fwd;

    // Branch compare on forwarded values
    assign breq = rs1_fwd == rs2_fwd;
    assign brlt = ctrl.brun ? (rs1_fwd < rs2_fwd) : ($signed(rs1_fwd) < $signed(rs2_fwd));

endmodule

// File: hdl/ex_control.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module ex_control import rv_pkg::*; (
    input  rv_inst_u inst,
    input  rv_inst_u mem_inst,
    input  rv_inst_u wb_inst,
    input  logic     breq,
    input  logic     brlt,
    input  logic     br_taken,
    output ex_ctrl_t ctrl,
    output logic     br_mispred,
    output logic     br_suc,
    output logic     flush
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       has_rs1;
    logic       has_rs2;
    logic       mem_has_rd;
    logic       wb_has_rd;
    logic       is_branch;
    logic       br_real;

    assign opcode = inst.r.opcode;
    assign funct3 = inst.r.funct3;

    // x0 is never a forwarding source
    assign has_rs1 = inst.r.rs1 != 5'd0
                  && opcode != `OPC_LUI && opcode != `OPC_AUIPC && opcode != `OPC_JAL
                  && !(opcode == `OPC_CSR && funct3 == `FNC_CSRRWI);
    assign has_rs2 = inst.r.rs2 != 5'd0
                  && (opcode == `OPC_ARI_RTYPE || opcode == `OPC_STORE
                      || opcode == `OPC_BRANCH);

    assign mem_has_rd = mem_inst.r.rd != 5'd0
                     && mem_inst.r.opcode != `OPC_STORE && mem_inst.r.opcode != `OPC_BRANCH;
    assign wb_has_rd  = wb_inst.r.rd != 5'd0
                     && wb_inst.r.opcode != `OPC_STORE && wb_inst.r.opcode != `OPC_BRANCH;

    always_comb begin
        ctrl.brun        = 1'b0;
        ctrl.fwda        = `EX_FWD_NONE;
        ctrl.fwdb        = `EX_FWD_NONE;
        ctrl.asel        = `A_REG;
        ctrl.bsel        = `B_IMM;
        ctrl.alusel      = `ALU_ADD;
        ctrl.csr_mux_sel = `CSR_RD1;
        ctrl.csr_en      = 1'b0;

        // MEM holds the younger result
        if (has_rs1 && mem_has_rd && inst.r.rs1 == mem_inst.r.rd) begin
            ctrl.fwda = `EX_FWD_MEM;
        end else if (has_rs1 && wb_has_rd && inst.r.rs1 == wb_inst.r.rd) begin
            ctrl.fwda = `EX_FWD_WB;
        end
        if (has_rs2 && mem_has_rd && inst.r.rs2 == mem_inst.r.rd) begin
            ctrl.fwdb = `EX_FWD_MEM;
        end else if (has_rs2 && wb_has_rd && inst.r.rs2 == wb_inst.r.rd) begin
            ctrl.fwdb = `EX_FWD_WB;
        end

        case (opcode[6:2])
            `OPC_ARI_RTYPE_5, `OPC_ARI_ITYPE_5: begin
                if (opcode == `OPC_ARI_RTYPE) begin
                    ctrl.bsel = `B_REG;
                end
                case (funct3)
                    `FNC_ADD_SUB: begin
                        // ADDI has immediate bits in inst[30]
                        if (opcode == `OPC_ARI_RTYPE && inst.raw[30] == `FNC2_SUB) begin
                            ctrl.alusel = `ALU_SUB;
                        end
                    end
                    `FNC_SLL:     ctrl.alusel = `ALU_SLL;
                    `FNC_SLT:     ctrl.alusel = `ALU_SLT;
                    `FNC_SLTU:    ctrl.alusel = `ALU_SLTU;
                    `FNC_XOR:     ctrl.alusel = `ALU_XOR;
                    `FNC_OR:      ctrl.alusel = `ALU_OR;
                    `FNC_AND:     ctrl.alusel = `ALU_AND;
                    `FNC_SRL_SRA: ctrl.alusel = (inst.raw[30] == `FNC2_SRA) ? `ALU_SRA
                                                                           : `ALU_SRL;
                    default:      ctrl.alusel = `ALU_ADD;
                endcase
            end
            // Effective address
            `OPC_LOAD_5, `OPC_STORE_5: ctrl.alusel = `ALU_ADD;
            `OPC_BRANCH_5: begin
                ctrl.asel = `A_PC;
                ctrl.brun = (funct3 == `FNC_BLTU || funct3 == `FNC_BGEU);
            end
            `OPC_JAL_5, `OPC_JALR_5, `OPC_AUIPC_5: ctrl.asel = `A_PC;
            `OPC_LUI_5: ctrl.alusel = `ALU_BSEL;
            `OPC_CSR_5: begin
                ctrl.csr_en      = (funct3 == `FNC_CSRRW || funct3 == `FNC_CSRRWI);
                ctrl.csr_mux_sel = (funct3 == `FNC_CSRRWI) ? `CSR_IMM : `CSR_RD1;
            end
            default: ctrl.alusel = `ALU_ADD;
        endcase
    end

    // Actual direction from the comparator flags
    always_comb begin
        case (funct3)
            `FNC_BEQ:            br_real = breq;
            `FNC_BNE:            br_real = !breq;
            `FNC_BLT, `FNC_BLTU: br_real = brlt;
            `FNC_BGE, `FNC_BGEU: br_real = !brlt;
            default:             br_real = 1'b0;
        endcase
    end

    assign is_branch  = opcode == `OPC_BRANCH;
    assign br_suc     = is_branch && (br_real == br_taken);
    assign br_mispred = is_branch && (br_real != br_taken);
    assign flush      = br_mispred;

    always_comb begin
        assert final (!flush || (br_mispred && !br_suc))
            else $error("flush without a lone mispredict");
    end

endmodule

// File: hdl/rv_pkg.sv
`include "rv_macros.svh"

package rv_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t            r;
        i_fmt_t            i;
        s_fmt_t            s;
        b_fmt_t            b;
        u_fmt_t            u;
        j_fmt_t            j;
        logic [`XLEN-1:0]  raw;
    } rv_inst_u;

    typedef struct packed {
        logic       brun;
        logic [1:0] fwda;
        logic [1:0] fwdb;
        logic       asel;
        logic       bsel;
        logic [3:0] alusel;
        logic       csr_mux_sel;
        logic       csr_en;
    } ex_ctrl_t;

    typedef struct packed {
        logic             valid;
        rv_inst_u         inst;
        logic [`XLEN-1:0] alu_result;
        logic [`XLEN-1:0] store_data;
    } ex_mem_t;

endpackage

// File: hdl/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define XLEN            32
`define NOP_INST        32'h0000_0013

// Opcodes
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_ARI_ITYPE   7'b0010011
`define OPC_ARI_RTYPE   7'b0110011
`define OPC_CSR         7'b1110011

// Upper five opcode bits for the decode case
`define OPC_LUI_5       5'b01101
`define OPC_AUIPC_5     5'b00101
`define OPC_JAL_5       5'b11011
`define OPC_JALR_5      5'b11001
`define OPC_BRANCH_5    5'b11000
`define OPC_LOAD_5      5'b00000
`define OPC_STORE_5     5'b01000
`define OPC_ARI_ITYPE_5 5'b00100
`define OPC_ARI_RTYPE_5 5'b01100
`define OPC_CSR_5       5'b11100

`define FNC_ADD_SUB     3'b000
`define FNC_SLL         3'b001
`define FNC_SLT         3'b010
`define FNC_SLTU        3'b011
`define FNC_XOR         3'b100
`define FNC_SRL_SRA     3'b101
`define FNC_OR          3'b110
`define FNC_AND         3'b111

// inst[30]
`define FNC2_SUB        1'b1
`define FNC2_SRA        1'b1

`define FNC_BEQ         3'b000
`define FNC_BNE         3'b001
`define FNC_BLT         3'b100
`define FNC_BGE         3'b101
`define FNC_BLTU        3'b110
`define FNC_BGEU        3'b111

`define FNC_CSRRW       3'b001
`define FNC_CSRRWI      3'b101

`define EX_FWD_NONE     2'd0
`define EX_FWD_MEM      2'd1
`define EX_FWD_WB       2'd2

`define A_REG           1'b0
`define A_PC            1'b1
`define B_REG           1'b0
`define B_IMM           1'b1
`define CSR_RD1         1'b0
`define CSR_IMM         1'b1

`define ALU_ADD         4'd0
`define ALU_SUB         4'd1
`define ALU_AND         4'd2
`define ALU_OR          4'd3
`define ALU_XOR         4'd4
`define ALU_SLL         4'd5
`define ALU_SRL         4'd6
`define ALU_SRA         4'd7
`define ALU_SLT         4'd8
`define ALU_SLTU        4'd9
`define ALU_BSEL        4'd10

`define CSR_TOHOST      12'h51E

`endif
